/* Makefile */
# Verilator build and run for the IPbus fabric testbench

VERILATOR ?= verilator
TOP       ?= tb_ipb_fabric
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

test: $(BIN)
	@$(BIN) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q '\*\* FAIL \*\*' $(LOG); then \
	  echo "test failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* afe_dac/afe_dac_intf.sv */
// AFE DAC register slave
module afe_dac_intf #(
  parameter int SCLK_DIV = 2
) (
  input  logic                           ipb_clk,
  input  logic                           reset,
  input  logic                           sel,
  input  logic                           io_wr_en,
  input  logic                           io_rd_en,
  input  logic [ipb_pkg::REG_W-1:0]      reg_addr,
  input  logic [ipb_pkg::IPB_DATA_W-1:0] wr_data,
  output logic [ipb_pkg::IPB_DATA_W-1:0] rd_data,
  output logic                           rd_ack,
  output logic                           sclk,
  output logic                           sdi,
  output logic                           sync_n    // low around the word
);
  import ipb_pkg::*;

  localparam int TAIL_W = $clog2(2 * SCLK_DIV + 1);

  logic [AFE_DAC_WORD_W-1:0] last_word;
  logic [TAIL_W-1:0]         tail_cnt;
  logic                      tail;       // sync_n hold after the frame
  logic                      wr_word;
  logic                      load;
  logic                      rd_fire;
  logic                      rd_en_q;
  logic                      busy;
  logic                      frame;
  logic                      done;
  logic                      overrun;

  assign wr_word = sel & io_wr_en & (reg_e'(reg_addr) == reg_word);
  assign load    = wr_word & ~busy;
  assign rd_fire = sel & io_rd_en & ~rd_en_q;
  assign sync_n  = ~(frame | done | tail);   // no gap between frame and tail

  serial_word_tx #(
    .WORD_W   (AFE_DAC_WORD_W),
    .SCLK_DIV (SCLK_DIV)
  ) u_tx (
    .ipb_clk (ipb_clk),
    .reset   (reset),
    .load    (load),
    .word    (wr_data[AFE_DAC_WORD_W-1:0]),  // low 24 bits only
    .busy    (busy),
    .sclk    (sclk),
    .sdata   (sdi),
    .frame   (frame),
    .done    (done)
  );

  ////////////////////////////////////////////////////////////
  // control, status, sync_n tail
  always_ff @(posedge ipb_clk) begin
    if (reset) begin
      rd_en_q  <= 1'b0;
      rd_ack   <= 1'b0;
      overrun  <= 1'b0;
      tail     <= 1'b0;
      tail_cnt <= '0;
    end else begin
      rd_en_q <= io_rd_en;
      rd_ack  <= rd_fire;
      if (wr_word && busy) begin
        overrun <= 1'b1;
      end else if (rd_fire && reg_e'(reg_addr) == reg_status) begin
        overrun <= 1'b0;
      end
      if (done) begin          // one extra serial period
        tail     <= 1'b1;
        tail_cnt <= '0;
      end else if (tail) begin
        if (tail_cnt == TAIL_W'(2 * SCLK_DIV - 1)) begin
          tail <= 1'b0;
        end
        tail_cnt <= tail_cnt + 1'b1;
      end
    end
  end

  // readback, reg_sync has no bit here
  always_ff @(posedge ipb_clk) begin
    if (load) begin
      last_word <= wr_data[AFE_DAC_WORD_W-1:0];
    end
    if (rd_fire) begin
      case (reg_e'(reg_addr))
        reg_word:   rd_data <= IPB_DATA_W'(last_word);
        reg_status: rd_data <= {{(IPB_DATA_W-2){1'b0}}, overrun, busy};
        default:    rd_data <= '0;
      endcase
    end
  end

endmodule

/* bench/tb_ipb_fabric.sv */
// IPbus fabric testbench
// table driven, with serial line monitors
module tb_ipb_fabric;
  import ipb_pkg::*;

  localparam int SCLK_DIV  = 2;
  localparam int RESET_CYC = 10;
  localparam int MAX_ROWS  = 48;
  // longest word on the lines, plus the dlen tail
  localparam int FRAME_CYC = 1 + CLK_SYNTH_WORD_W * 2 * SCLK_DIV + 2 * SCLK_DIV;
  localparam int ROW_CYC   = FRAME_CYC + 20;  // frame plus bus overhead

  typedef enum {
    act_write,     // bus write
    act_read,      // bus read, compare data
    act_wait_cs,   // wait for a synth word on ddat
    act_wait_dac,  // wait for a DAC word on sdi
    act_quiet,     // one frame time, nothing may be shifted
    act_sync_pin   // compare adcclk_sync
  } act_e;

  logic                  ipb_clk;
  logic                  reset;
  logic                  ipb_strobe;
  logic                  ipb_write;
  logic [IPB_ADDR_W-1:0] ipb_addr;
  logic [IPB_DATA_W-1:0] ipb_wdata;
  logic [IPB_DATA_W-1:0] ipb_rdata;
  logic                  ipb_ack;
  logic                  adcclk_dclk;
  logic                  adcclk_ddat;
  logic                  adcclk_dlen;
  logic                  adcclk_sync;
  logic                  afe_dac_sclk;
  logic                  afe_dac_sdi;
  logic                  afe_dac_sync_n;

  // stimulus table
  act_e                  row_act  [MAX_ROWS];
  logic [IPB_ADDR_W-1:0] row_addr [MAX_ROWS];
  logic [IPB_DATA_W-1:0] row_data [MAX_ROWS];
  logic [IPB_DATA_W-1:0] row_exp  [MAX_ROWS];
  int                    row_hold [MAX_ROWS];  // extra cycles strobe stays up
  int                    n_rows = 0;

  // captured serial words
  logic [CLK_SYNTH_WORD_W-1:0] cs_words[$];
  int                          cs_counts[$];
  logic [AFE_DAC_WORD_W-1:0]   dac_words[$];
  int                          dac_counts[$];
  logic [CLK_SYNTH_WORD_W-1:0] cs_shift = '0;
  logic [AFE_DAC_WORD_W-1:0]   dac_shift = '0;
  int                          cs_bits = 0;
  int                          dac_bits = 0;
  int                          dlen_width = 0;

  logic [31:0] lcg_state = 32'd72;
  int          n_checks = 0;
  int          n_errors = 0;
  int          cycle_cnt = 0;
  int          cycle_limit = 0;

  ipb_fabric_top #(.SCLK_DIV(SCLK_DIV)) dut (
    .ipb_clk        (ipb_clk),
    .reset          (reset),
    .ipb_strobe     (ipb_strobe),
    .ipb_write      (ipb_write),
    .ipb_addr       (ipb_addr),
    .ipb_wdata      (ipb_wdata),
    .ipb_rdata      (ipb_rdata),
    .ipb_ack        (ipb_ack),
    .adcclk_dclk    (adcclk_dclk),
    .adcclk_ddat    (adcclk_ddat),
    .adcclk_dlen    (adcclk_dlen),
    .adcclk_sync    (adcclk_sync),
    .afe_dac_sclk   (afe_dac_sclk),
    .afe_dac_sdi    (afe_dac_sdi),
    .afe_dac_sync_n (afe_dac_sync_n)
  );

  initial ipb_clk = 1'b0;
  always #2 ipb_clk = ~ipb_clk;  // period 4

  // run limit from the table length
  always @(posedge ipb_clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("** FAIL **");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // serial line monitors
  always @(posedge adcclk_dclk) begin
    cs_shift = {cs_shift[CLK_SYNTH_WORD_W-2:0], adcclk_ddat};  // MSB first
    cs_bits++;
  end

  always @(posedge adcclk_dlen) begin
    cs_words.push_back(cs_shift);
    cs_counts.push_back(cs_bits);
    cs_shift = '0;
    cs_bits = 0;
    dlen_width = 0;
    do begin
      @(negedge ipb_clk);
      if (adcclk_dlen) dlen_width++;
    end while (adcclk_dlen);
    check_count(dlen_width, 2 * SCLK_DIV, "dlen width in ipb_clk cycles");
  end

  always @(posedge afe_dac_sclk) begin
    if (!afe_dac_sync_n) begin
      dac_shift = {dac_shift[AFE_DAC_WORD_W-2:0], afe_dac_sdi};
      dac_bits++;
    end else begin
      $display("error at %0t: sclk rose while sync_n was high", $time);
      n_errors++;
    end
  end

  always @(posedge afe_dac_sync_n) begin
    if (!reset) begin  // skip the rise out of x at reset
      dac_words.push_back(dac_shift);
      dac_counts.push_back(dac_bits);
      dac_shift = '0;
      dac_bits = 0;
    end
  end

  ////////////////////////////////////////////////////////////
  // helpers
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [IPB_ADDR_W-1:0] slot_reg_addr(input logic [SLOT_W-1:0] slot,
                                                          input logic [REG_W-1:0] r);
    return {slot, {(IPB_ADDR_W - SLOT_W - REG_W){1'b0}}, r};
  endfunction

  task automatic add_row(input act_e act, input logic [IPB_ADDR_W-1:0] addr,
                         input logic [IPB_DATA_W-1:0] data,
                         input logic [IPB_DATA_W-1:0] exp, input int hold);
    row_act[n_rows]  = act;
    row_addr[n_rows] = addr;
    row_data[n_rows] = data;
    row_exp[n_rows]  = exp;
    row_hold[n_rows] = hold;
    n_rows++;
  endtask

  task automatic check_rdata(input logic [IPB_DATA_W-1:0] got,
                             input logic [IPB_DATA_W-1:0] exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("mismatch at %0t: %s gave %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_cs_word(input logic [CLK_SYNTH_WORD_W-1:0] got,
                               input logic [CLK_SYNTH_WORD_W-1:0] exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("mismatch at %0t: %s shifted %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_dac_word(input logic [AFE_DAC_WORD_W-1:0] got,
                                input logic [AFE_DAC_WORD_W-1:0] exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("mismatch at %0t: %s shifted %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    n_checks++;
    if (got != exp) begin
      n_errors++;
      $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // one IPbus access, called and left 1 unit after a rising edge
  task automatic ipb_access(input logic wr, input logic [IPB_ADDR_W-1:0] addr,
                            input logic [IPB_DATA_W-1:0] wdata, input int hold,
                            output logic [IPB_DATA_W-1:0] rdata);
    int lat;
    ipb_strobe = 1'b1;
    ipb_write  = wr;
    ipb_addr   = addr;
    ipb_wdata  = wdata;
    lat = 0;
    do begin
      @(posedge ipb_clk);
      #1;
      lat++;
    end while (!ipb_ack);
    check_count(lat, wr ? 2 : 4, wr ? "write ack latency" : "read ack latency");
    rdata = ipb_rdata;
    repeat (hold) begin
      @(posedge ipb_clk);
      #1;
      check_bit(ipb_ack, 1'b0, "ack while strobe held");
    end
    ipb_strobe = 1'b0;
    @(posedge ipb_clk);
    #1;
    check_bit(ipb_ack, 1'b0, "ack after strobe drop");
    @(posedge ipb_clk);  // FSM back in idle
    #1;
  endtask

  ////////////////////////////////////////////////////////////
  // table and main sequence
  initial begin
    logic [IPB_DATA_W-1:0] rdata;
    logic [IPB_DATA_W-1:0] w1;
    logic [IPB_DATA_W-1:0] w2;
    logic [IPB_DATA_W-1:0] w3;
    logic [IPB_DATA_W-1:0] w4;
    logic [IPB_DATA_W-1:0] w5;
    logic [IPB_ADDR_W-1:0] cs_word;
    logic [IPB_ADDR_W-1:0] cs_stat;
    logic [IPB_ADDR_W-1:0] cs_sync;
    logic [IPB_ADDR_W-1:0] dac_word;
    logic [IPB_ADDR_W-1:0] dac_stat;

    reset      = 1'b1;
    ipb_strobe = 1'b0;
    ipb_write  = 1'b0;
    ipb_addr   = '0;
    ipb_wdata  = '0;

    w1 = lcg_next();
    w2 = lcg_next();
    w3 = lcg_next();
    w4 = lcg_next();
    w5 = lcg_next();
    cs_word  = slot_reg_addr(slot_clk_synth, reg_word);
    cs_stat  = slot_reg_addr(slot_clk_synth, reg_status);
    cs_sync  = slot_reg_addr(slot_clk_synth, reg_sync);
    dac_word = slot_reg_addr(slot_afe_dac, reg_word);
    dac_stat = slot_reg_addr(slot_afe_dac, reg_status);

    add_row(act_read,     cs_stat,  '0, 32'h0, 0);   // idle status
    add_row(act_read,     dac_stat, '0, 32'h0, 0);
    add_row(act_write,    cs_word,  w1, '0, 3);      // strobe held past ack
    add_row(act_wait_cs,  '0,       '0, w1, 0);
    add_row(act_read,     cs_word,  '0, w1, 2);
    add_row(act_write,    dac_word, w2, '0, 0);
    add_row(act_wait_dac, '0,       '0, {8'h0, w2[23:0]}, 0);
    add_row(act_read,     dac_word, '0, {8'h0, w2[23:0]}, 0);
    add_row(act_write,    cs_word,  w3, '0, 0);
    add_row(act_write,    cs_word,  w4, '0, 0);      // lands while busy
    add_row(act_wait_cs,  '0,       '0, w3, 0);
    add_row(act_read,     cs_stat,  '0, 32'h2, 0);   // overrun, not busy
    add_row(act_read,     cs_stat,  '0, 32'h0, 0);   // cleared by last read
    add_row(act_quiet,    '0,       '0, '0, 0);
    add_row(act_read,     cs_word,  '0, w3, 0);
    add_row(act_write,    cs_sync,  32'h1, '0, 0);
    add_row(act_sync_pin, '0,       '0, 32'h1, 0);
    add_row(act_read,     cs_sync,  '0, 32'h1, 0);
    add_row(act_write,    cs_sync,  32'hffff_fffe, '0, 0);
    add_row(act_sync_pin, '0,       '0, 32'h0, 0);
    // unmapped slots
    add_row(act_read,     slot_reg_addr(4'd0, reg_word),   '0, 32'h0, 0);
    add_row(act_read,     slot_reg_addr(4'd9, reg_status), '0, 32'h0, 0);
    add_row(act_write,    slot_reg_addr(4'd9, reg_word),   lcg_next(), '0, 0);
    add_row(act_write,    slot_reg_addr(4'd0, reg_sync),   32'h1, '0, 0);
    add_row(act_quiet,    '0,       '0, '0, 0);
    add_row(act_sync_pin, '0,       '0, 32'h0, 0);
    add_row(act_read,     cs_word,  '0, w3, 0);
    add_row(act_read,     dac_stat, '0, 32'h0, 0);
    add_row(act_write,    dac_word, w5, '0, 0);
    add_row(act_wait_dac, '0,       '0, {8'h0, w5[23:0]}, 0);
    add_row(act_read,     dac_word, '0, {8'h0, w5[23:0]}, 0);
    cycle_limit = n_rows * ROW_CYC + RESET_CYC + 100;

    repeat (RESET_CYC) @(posedge ipb_clk);
    #1;
    reset = 1'b0;

    check_bit(afe_dac_sync_n, 1'b1, "sync_n after reset");
    check_bit(adcclk_dlen, 1'b0, "dlen after reset");
    check_bit(ipb_ack, 1'b0, "ack after reset");
    check_rdata(ipb_rdata, '0, "rdata after reset");

    for (int i = 0; i < n_rows; i++) begin
      case (row_act[i])
        act_write: begin
          ipb_access(1'b1, row_addr[i], row_data[i], row_hold[i], rdata);
        end
        act_read: begin
          ipb_access(1'b0, row_addr[i], '0, row_hold[i], rdata);
          check_rdata(rdata, row_exp[i], $sformatf("row %0d read of %h", i, row_addr[i]));
        end
        act_wait_cs: begin
          while (cs_words.size() == 0) begin
            @(posedge ipb_clk);
            #1;
          end
          check_cs_word(cs_words.pop_front(), row_exp[i], $sformatf("row %0d ddat", i));
          check_count(cs_counts.pop_front(), CLK_SYNTH_WORD_W, "ddat bit count");
        end
        act_wait_dac: begin
          while (dac_words.size() == 0) begin
            @(posedge ipb_clk);
            #1;
          end
          check_dac_word(dac_words.pop_front(), row_exp[i][AFE_DAC_WORD_W-1:0],
                         $sformatf("row %0d sdi", i));
          check_count(dac_counts.pop_front(), AFE_DAC_WORD_W, "sdi bit count");
          check_bit(afe_dac_sync_n, 1'b1, "sync_n after word");
        end
        act_quiet: begin
          repeat (FRAME_CYC) begin
            @(posedge ipb_clk);
            #1;
          end
          check_count(cs_words.size() + cs_bits, 0, "stray ddat activity");
          check_count(dac_words.size() + dac_bits, 0, "stray sdi activity");
        end
        default: begin
          check_bit(adcclk_sync, row_exp[i][0], $sformatf("row %0d adcclk_sync", i));
        end
      endcase
    end

    check_bit(afe_dac_sync_n, 1'b1, "sync_n at end");
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* build.f */
common/ipb_pkg.sv
src/serial_word_tx.sv
clk_synth/clk_synth_intf.sv
afe_dac/afe_dac_intf.sv
src/ipb_io_fsm.sv
src/ipb_slot_decode.sv
src/ipb_fabric_top.sv
bench/tb_ipb_fabric.sv

/* clk_synth/clk_synth_intf.sv */
// ADC clock synthesizer register slave
module clk_synth_intf #(
  parameter int SCLK_DIV = 2
) (
  input  logic                           ipb_clk,
  input  logic                           reset,
  input  logic                           sel,       // slot selected
  input  logic                           io_wr_en,
  input  logic                           io_rd_en,
  input  logic [ipb_pkg::REG_W-1:0]      reg_addr,
  input  logic [ipb_pkg::IPB_DATA_W-1:0] wr_data,
  output logic [ipb_pkg::IPB_DATA_W-1:0] rd_data,
  output logic                           rd_ack,    // one cycle
  output logic                           dclk,
  output logic                           ddat,
  output logic                           dlen,      // latch pulse after word
  output logic                           sync
);
  import ipb_pkg::*;

  localparam int LEN_W = $clog2(2 * SCLK_DIV + 1);

  logic [CLK_SYNTH_WORD_W-1:0] last_word;  // last word accepted
  logic [LEN_W-1:0]            len_cnt;
  logic                        wr_word;
  logic                        load;
  logic                        rd_fire;
  logic                        rd_en_q;
  logic                        busy;
  logic                        done;
  logic                        overrun;    // sticky, cleared by status read

  assign wr_word = sel & io_wr_en & (reg_e'(reg_addr) == reg_word);
  assign load    = wr_word & ~busy;          // drop word while shifting
  assign rd_fire = sel & io_rd_en & ~rd_en_q;  // first cycle of the read

  serial_word_tx #(
    .WORD_W   (CLK_SYNTH_WORD_W),
    .SCLK_DIV (SCLK_DIV)
  ) u_tx (
    .ipb_clk (ipb_clk),
    .reset   (reset),
    .load    (load),
    .word    (wr_data[CLK_SYNTH_WORD_W-1:0]),
    .busy    (busy),
    .sclk    (dclk),
    .sdata   (ddat),
    .frame   (),
    .done    (done)
  );

  ////////////////////////////////////////////////////////////
  // control and status
  always_ff @(posedge ipb_clk) begin
    if (reset) begin
      rd_en_q <= 1'b0;
      rd_ack  <= 1'b0;
      overrun <= 1'b0;
      sync    <= 1'b0;
      dlen    <= 1'b0;
      len_cnt <= '0;
    end else begin
      rd_en_q <= io_rd_en;
      rd_ack  <= rd_fire;
      if (wr_word && busy) begin
        overrun <= 1'b1;
      end else if (rd_fire && reg_e'(reg_addr) == reg_status) begin
        overrun <= 1'b0;
      end
      if (sel && io_wr_en && reg_e'(reg_addr) == reg_sync) begin
        sync <= wr_data[0];
      end
      // dlen lasts one serial clock period
      if (done) begin
        dlen    <= 1'b1;
        len_cnt <= '0;
      end else if (dlen) begin
        if (len_cnt == LEN_W'(2 * SCLK_DIV - 1)) begin
          dlen <= 1'b0;
        end
        len_cnt <= len_cnt + 1'b1;
      end
    end
  end

  // word copy and readback
  always_ff @(posedge ipb_clk) begin
    if (load) begin
      last_word <= wr_data[CLK_SYNTH_WORD_W-1:0];
    end
    if (rd_fire) begin
      case (reg_e'(reg_addr))
        reg_word:   rd_data <= IPB_DATA_W'(last_word);
        reg_status: rd_data <= {{(IPB_DATA_W-2){1'b0}}, overrun, busy};
        reg_sync:   rd_data <= {{(IPB_DATA_W-1){1'b0}}, sync};
        default:    rd_data <= '0;
      endcase
    end
  end

endmodule

/* common/ipb_pkg.sv */
// IPbus register fabric
// shared widths and encodings
package ipb_pkg;

  ////////////////////////////////////////////////////////////
  // bus widths
  localparam int IPB_ADDR_W = 24;   // slave address from the master
  localparam int IPB_DATA_W = 32;   // read and write data
  localparam int SLOT_W     = 4;    // addr bits 23:20 pick the slot
  localparam int REG_W      = 2;    // low addr bits pick the register

  ////////////////////////////////////////////////////////////
  // serial word lengths
  localparam int CLK_SYNTH_WORD_W = 32;  // clock synthesizer word
  localparam int AFE_DAC_WORD_W   = 24;  // AFE DAC word

  // slot map, top address nibble
  typedef enum logic [SLOT_W-1:0] {
    slot_chan0     = 4'd0,   // channel slots are unmapped here
    slot_chan1     = 4'd1,
    slot_chan2     = 4'd2,
    slot_chan3     = 4'd3,
    slot_chan4     = 4'd4,
    slot_clk_synth = 4'd5,   // ADC clock synthesizer
    slot_afe_dac   = 4'd6    // AFE DAC, 7 and up reserved
  } slot_e;

  // register offsets inside a serial slave
  typedef enum logic [REG_W-1:0] {
    reg_word   = 2'd0,   // write sends the word, read gives last sent
    reg_status = 2'd1,   // busy and sticky overrun
    reg_sync   = 2'd2    // control bit
  } reg_e;

  // transaction FSM states
  typedef enum logic [2:0] {
    st_idle,
    st_write,       // one cycle of io_wr_en
    st_read_wait,   // io_rd_en held until readback ack
    st_ack,         // ipb_ack pulse
    st_release      // wait for strobe low
  } io_state_e;

endpackage

/* src/ipb_fabric_top.sv */
// IPbus fabric top with serial config slaves
module ipb_fabric_top #(
  parameter int SCLK_DIV = 2   // ipb_clk cycles per serial half-period
) (
  input  logic                           ipb_clk,
  input  logic                           reset,       // sync, active high
  input  logic                           ipb_strobe,  // access requested
  input  logic                           ipb_write,   // write when high
  input  logic [ipb_pkg::IPB_ADDR_W-1:0] ipb_addr,
  input  logic [ipb_pkg::IPB_DATA_W-1:0] ipb_wdata,
  output logic [ipb_pkg::IPB_DATA_W-1:0] ipb_rdata,
  output logic                           ipb_ack,     // one cycle pulse
  output logic                           adcclk_dclk,
  output logic                           adcclk_ddat,
  output logic                           adcclk_dlen,
  output logic                           adcclk_sync,
  output logic                           afe_dac_sclk,
  output logic                           afe_dac_sdi,
  output logic                           afe_dac_sync_n
);
  import ipb_pkg::*;

  logic                  io_rd_en;     // read in progress
  logic                  io_wr_en;     // one cycle write strobe
  logic                  io_rd_ack;    // registered merged read ack
  logic                  cs_sel;       // clock synth slot
  logic                  dac_sel;      // DAC slot
  logic                  cs_rd_ack;
  logic                  dac_rd_ack;
  logic [IPB_DATA_W-1:0] cs_rd_data;
  logic [IPB_DATA_W-1:0] dac_rd_data;

  ////////////////////////////////////////////////////////////
  // transaction control
  ipb_io_fsm u_fsm (
    .ipb_clk    (ipb_clk),
    .reset      (reset),
    .ipb_strobe (ipb_strobe),
    .ipb_write  (ipb_write),
    .io_rd_ack  (io_rd_ack),
    .io_sync    (),            // high for the whole operation
    .io_rd_en   (io_rd_en),
    .io_wr_en   (io_wr_en),
    .ipb_ack    (ipb_ack)
  );

  // slot decode and readback mux
  ipb_slot_decode u_decode (
    .ipb_clk     (ipb_clk),
    .reset       (reset),
    .ipb_addr    (ipb_addr),
    .io_rd_en    (io_rd_en),
    .cs_rd_ack   (cs_rd_ack),
    .cs_rd_data  (cs_rd_data),
    .dac_rd_ack  (dac_rd_ack),
    .dac_rd_data (dac_rd_data),
    .cs_sel      (cs_sel),
    .dac_sel     (dac_sel),
    .io_rd_ack   (io_rd_ack),
    .ipb_rdata   (ipb_rdata)
  );

  ////////////////////////////////////////////////////////////
  // serial slaves
  clk_synth_intf #(.SCLK_DIV(SCLK_DIV)) u_clk_synth (
    .ipb_clk  (ipb_clk),
    .reset    (reset),
    .sel      (cs_sel),
    .io_wr_en (io_wr_en),
    .io_rd_en (io_rd_en),
    .reg_addr (ipb_addr[REG_W-1:0]),   // offset bits above these ignored
    .wr_data  (ipb_wdata),
    .rd_data  (cs_rd_data),
    .rd_ack   (cs_rd_ack),
    .dclk     (adcclk_dclk),
    .ddat     (adcclk_ddat),
    .dlen     (adcclk_dlen),
    .sync     (adcclk_sync)
  );

  afe_dac_intf #(.SCLK_DIV(SCLK_DIV)) u_afe_dac (
    .ipb_clk  (ipb_clk),
    .reset    (reset),
    .sel      (dac_sel),
    .io_wr_en (io_wr_en),
    .io_rd_en (io_rd_en),
    .reg_addr (ipb_addr[REG_W-1:0]),
    .wr_data  (ipb_wdata),
    .rd_data  (dac_rd_data),
    .rd_ack   (dac_rd_ack),
    .sclk     (afe_dac_sclk),
    .sdi      (afe_dac_sdi),
    .sync_n   (afe_dac_sync_n)
  );

endmodule

/* src/ipb_io_fsm.sv */
// IPbus transaction state machine
module ipb_io_fsm (
  input  logic ipb_clk,
  input  logic reset,
  input  logic ipb_strobe,  // level, held by master until ack
  input  logic ipb_write,
  input  logic io_rd_ack,   // registered readback ack
  output logic io_sync,     // high for the whole operation
  output logic io_rd_en,    // held until the read ack
  output logic io_wr_en,    // single cycle
  output logic ipb_ack      // single cycle
);
  import ipb_pkg::*;

  io_state_e state;

  always_ff @(posedge ipb_clk) begin
    if (reset) begin
      state    <= st_idle;
      io_sync  <= 1'b0;
      io_rd_en <= 1'b0;
      io_wr_en <= 1'b0;
      ipb_ack  <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (ipb_strobe) begin
            io_sync <= 1'b1;
            if (ipb_write) begin
              io_wr_en <= 1'b1;      // target updates on the next edge
              state    <= st_write;
            end else begin
              io_rd_en <= 1'b1;
              state    <= st_read_wait;
            end
          end
        end
        st_write: begin
          io_wr_en <= 1'b0;
          ipb_ack  <= 1'b1;          // write is done, ack right away
          state    <= st_ack;
        end
        st_read_wait: begin
          if (io_rd_ack) begin       // data already in ipb_rdata
            io_rd_en <= 1'b0;
            ipb_ack  <= 1'b1;
            state    <= st_ack;
          end
        end
        st_ack: begin
          ipb_ack <= 1'b0;           // pulse only
          state   <= st_release;
        end
        st_release: begin
          // hold off a second access until the master lets go
          if (!ipb_strobe) begin
            io_sync <= 1'b0;
            state   <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

/* src/ipb_slot_decode.sv */
// slot decode and readback mux
module ipb_slot_decode (
  input  logic                           ipb_clk,
  input  logic                           reset,
  input  logic [ipb_pkg::IPB_ADDR_W-1:0] ipb_addr,
  input  logic                           io_rd_en,
  input  logic                           cs_rd_ack,
  input  logic [ipb_pkg::IPB_DATA_W-1:0] cs_rd_data,
  input  logic                           dac_rd_ack,
  input  logic [ipb_pkg::IPB_DATA_W-1:0] dac_rd_data,
  output logic                           cs_sel,
  output logic                           dac_sel,
  output logic                           io_rd_ack,
  output logic [ipb_pkg::IPB_DATA_W-1:0] ipb_rdata
);
  import ipb_pkg::*;

  slot_e slot;
  logic  unmapped;    // no slave answers this slot
  logic  rd_en_q;     // io_rd_en delayed, for edge detect
  logic  nomap_ack;   // stand-in ack for unmapped slots

  assign slot     = slot_e'(ipb_addr[IPB_ADDR_W-1 -: SLOT_W]);
  assign cs_sel   = (slot == slot_clk_synth);
  assign dac_sel  = (slot == slot_afe_dac);
  assign unmapped = ~(cs_sel | dac_sel);  // chan0-4 and 7-15

  ////////////////////////////////////////////////////////////
  // merged ack and data, one register stage
  always_ff @(posedge ipb_clk) begin
    if (reset) begin
      rd_en_q   <= 1'b0;
      nomap_ack <= 1'b0;
      io_rd_ack <= 1'b0;
      ipb_rdata <= '0;
    end else begin
      rd_en_q   <= io_rd_en;
      nomap_ack <= io_rd_en & ~rd_en_q & unmapped;  // same delay as a slave
      io_rd_ack <= io_rd_en & (cs_rd_ack | dac_rd_ack | nomap_ack);
      // steer data of whoever acked, hold otherwise
      if (cs_rd_ack) begin
        ipb_rdata <= cs_rd_data;
      end else if (dac_rd_ack) begin
        ipb_rdata <= dac_rd_data;
      end else if (nomap_ack) begin
        ipb_rdata <= '0;           // unmapped reads as zero
      end
    end
  end

endmodule

/* src/serial_word_tx.sv */
// serial word shifter, MSB first
module serial_word_tx #(
  parameter int WORD_W   = 32,  // bits per word
  parameter int SCLK_DIV = 2    // ipb_clk cycles per half-period
) (
  input  logic              ipb_clk,
  input  logic              reset,
  input  logic              load,    // start a word, ignored while busy
  input  logic [WORD_W-1:0] word,
  output logic              busy,    // shift plus done cycle
  output logic              sclk,
  output logic              sdata,
  output logic              frame,   // high while bits go out
  output logic              done     // one cycle after the last bit
);

  localparam int DIV_W = $clog2(SCLK_DIV + 1);
  localparam int BIT_W = $clog2(WORD_W);

  logic [WORD_W-1:0] shreg;
  logic [DIV_W-1:0]  div_cnt;    // cycles within a half-period
  logic [BIT_W-1:0]  bit_cnt;    // bits sent so far
  logic              half_end;   // last cycle of a half-period
  logic              last_bit;

  assign half_end = (div_cnt == DIV_W'(SCLK_DIV - 1));
  assign last_bit = (bit_cnt == BIT_W'(WORD_W - 1));
  assign sdata    = frame & shreg[WORD_W-1];  // idles low
  assign busy     = frame | done;

  // data register, moves on the falling sclk edge
  always_ff @(posedge ipb_clk) begin
    if (load && !busy) begin
      shreg <= word;
    end else if (frame && half_end && sclk) begin
      shreg <= {shreg[WORD_W-2:0], 1'b0};
    end
  end

  ////////////////////////////////////////////////////////////
  // divider and bit counter
  always_ff @(posedge ipb_clk) begin
    if (reset) begin
      frame   <= 1'b0;
      sclk    <= 1'b0;
      done    <= 1'b0;
      div_cnt <= '0;
      bit_cnt <= '0;
    end else begin
      done <= 1'b0;
      if (!frame) begin
        if (load && !busy) begin
          frame   <= 1'b1;         // sclk low, MSB already on sdata
          div_cnt <= '0;
          bit_cnt <= '0;
        end
      end else if (half_end) begin
        div_cnt <= '0;
        sclk    <= ~sclk;
        if (sclk) begin            // high half over, bit period ends
          bit_cnt <= bit_cnt + 1'b1;
          if (last_bit) begin
            frame <= 1'b0;
            done  <= 1'b1;
          end
        end
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

endmodule
